// ==== src/sd_pkg.sv ====
package sd_pkg;

   // Frame geometry on the CMD line
   localparam int FRAME_W     = 48;   // Command and short response
   localparam int LONG_RESP_W = 136;  // R2 response
   localparam int CRC_SPAN    = 40;   // Bits covered by CRC7

   typedef logic [5:0]         sd_cmd_idx_t;
   typedef logic [31:0]        sd_arg_t;
   typedef logic [6:0]         sd_crc7_t;
   typedef logic [FRAME_W-1:0] sd_frame_t;
   typedef logic [127:0]       sd_cid_t;
   typedef logic [15:0]        sd_rca_t;

   // Request from sequencer to transmitter
   typedef struct packed {
      sd_cmd_idx_t idx;
      sd_arg_t     arg;
   } sd_cmd_t;

   // Sets response length and CRC check in the receiver
   typedef enum logic [2:0] {
      RESP_NONE,
      RESP_R1,
      RESP_R2,
      RESP_R3,
      RESP_R6,
      RESP_R7
   } sd_resp_kind_e;

   // Short responses sit in the low 48 bits of payload
   typedef struct packed {
      logic [LONG_RESP_W-1:0] payload;
      logic                   crc_ok;
      logic                   timeout;
   } sd_resp_t;

   // Command indices used during init
   localparam sd_cmd_idx_t CMD0_IDX  = 6'd0;   // GO_IDLE_STATE
   localparam sd_cmd_idx_t CMD2_IDX  = 6'd2;   // ALL_SEND_CID
   localparam sd_cmd_idx_t CMD3_IDX  = 6'd3;   // SEND_RELATIVE_ADDR
   localparam sd_cmd_idx_t CMD8_IDX  = 6'd8;   // SEND_IF_COND
   localparam sd_cmd_idx_t CMD41_IDX = 6'd41;  // SD_SEND_OP_COND, app cmd
   localparam sd_cmd_idx_t CMD55_IDX = 6'd55;  // APP_CMD

   // 2.7-3.6 V supply, check pattern in low byte
   localparam sd_arg_t CMD8_ARG   = 32'h0000_01AA;
   // HCS set, OCR window 3.2-3.4 V
   localparam sd_arg_t ACMD41_ARG = 32'h4030_0000;

   // x^7 + x^3 + 1, the x^7 term implied by the shift
   localparam sd_crc7_t CRC7_POLY = 7'h09;

endpackage

// ==== src/sd_clk_gen.sv ====
`timescale 1ns/1ps

module sd_clk_gen #(
   parameter int SD_CLK_HALF = 2
) (
   input  logic CLK,
   input  logic arst_n,
   output logic sd_clk,
   output logic sd_rise,
   output logic sd_fall
);

   localparam int CW = $clog2(SD_CLK_HALF + 1);

   logic [CW-1:0] half_cnt;  // CLK cycles within current half period
   logic          half_end;

   assign half_end = (half_cnt == CW'(SD_CLK_HALF - 1));

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         half_cnt <= '0;
         sd_clk   <= 1'b0;  // Idles low, first edge is a rise
         sd_rise  <= 1'b0;
         sd_fall  <= 1'b0;
      end
      else
      begin
         sd_rise <= half_end && !sd_clk;  // Strobe lines up with the new level
         sd_fall <= half_end && sd_clk;
         if (half_end)
         begin
            half_cnt <= '0;
            sd_clk   <= ~sd_clk;
         end
         else
            half_cnt <= half_cnt + 1'b1;
      end
   end

   // Line engines rely on rise and fall being distinct cycles
   a_edge_excl : assert property (@(posedge CLK) disable iff (!arst_n)
      (sd_rise || sd_fall) |=> !(sd_rise || sd_fall) || (SD_CLK_HALF == 1));

endmodule

// ==== src/sd_crc7.sv ====
`timescale 1ns/1ps

module sd_crc7 (
   input  logic             CLK,
   input  logic             arst_n,
   input  logic             clear,
   input  logic             shift,
   input  logic             din,
   output sd_pkg::sd_crc7_t crc
);

   import sd_pkg::*;

   logic fb;  // Feedback into the polynomial taps

   // MSB out, next message bit in
   assign fb = din ^ crc[6];

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
         crc <= '0;
      else if (clear)
         crc <= '0;  // Start of a new frame
      else if (shift)
      begin
         // Galois form, taps at x^3 and x^0
         if (fb)
            crc <= {crc[5:0], 1'b0} ^ CRC7_POLY;
         else
            crc <= {crc[5:0], 1'b0};
      end
   end

endmodule

// ==== src/sd_cmd_tx.sv ====
`timescale 1ns/1ps

module sd_cmd_tx (
   input  logic            CLK,
   input  logic            arst_n,
   input  logic            sd_fall,
   input  logic            tx_req,
   input  sd_pkg::sd_cmd_t tx_cmd,
   output logic            tx_ack,
   output logic            cmd_out,
   output logic            cmd_oe
);

   import sd_pkg::*;

   typedef enum logic [1:0] {IDLE, SEND, DONE} tx_state_e;

   tx_state_e state;
   sd_frame_t frame;     // Start, transmission, index, argument, then filler
   logic [5:0] bit_cnt;  // Bit being driven next fall
   sd_crc7_t  crc;
   logic      crc_bit;
   logic      crc_clr;
   logic      crc_shift;

   // CRC field goes out MSB first
   assign crc_bit   = crc[3'(6'd46 - bit_cnt)];
   assign crc_clr   = (state == IDLE) && tx_req;
   assign crc_shift = (state == SEND) && sd_fall && (bit_cnt < 6'(CRC_SPAN));

   sd_crc7 u_crc (
      .CLK    (CLK),
      .arst_n (arst_n),
      .clear  (crc_clr),
      .shift  (crc_shift),
      .din    (frame[FRAME_W-1]),
      .crc    (crc)
   );

   // Frame register, payload only
   always_ff @(posedge CLK)
   begin
      if (crc_clr)
         frame <= {2'b01, tx_cmd.idx, tx_cmd.arg, 8'h01};
      else if (crc_shift)
         frame <= {frame[FRAME_W-2:0], 1'b1};
   end

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= IDLE;
         bit_cnt <= '0;
         tx_ack  <= 1'b0;
         cmd_out <= 1'b1;  // Line idles high
         cmd_oe  <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               bit_cnt <= '0;
               if (tx_req)
                  state <= SEND;
            end
            SEND:
            begin
               if (sd_fall)
               begin
                  bit_cnt <= bit_cnt + 1'b1;
                  cmd_oe  <= 1'b1;
                  if (bit_cnt < 6'(CRC_SPAN))
                     cmd_out <= frame[FRAME_W-1];  // Header and argument
                  else if (bit_cnt < 6'(FRAME_W - 1))
                     cmd_out <= crc_bit;
                  else if (bit_cnt == 6'(FRAME_W - 1))
                     cmd_out <= 1'b1;  // End bit
                  else
                  begin
                     // End bit has had its full SD clock
                     cmd_oe <= 1'b0;
                     tx_ack <= 1'b1;
                     state  <= DONE;
                  end
               end
            end
            default:
            begin
               if (!tx_req)
               begin
                  tx_ack <= 1'b0;  // Close the handshake
                  state  <= IDLE;
               end
            end
         endcase
      end
   end

   // Sequencer must hold the command until the frame is out
   a_cmd_stable : assert property (@(posedge CLK) disable iff (!arst_n)
      (tx_req && !tx_ack) ##1 (tx_req && !tx_ack) |-> $stable(tx_cmd));

endmodule

// ==== src/sd_resp_rx.sv ====
`timescale 1ns/1ps

module sd_resp_rx #(
   parameter int RESP_TIMEOUT = 64
) (
   input  logic                  CLK,
   input  logic                  arst_n,
   input  logic                  sd_rise,
   input  logic                  cmd_in,
   input  logic                  rx_req,
   input  sd_pkg::sd_resp_kind_e rx_kind,
   output logic                  rx_ack,
   output sd_pkg::sd_resp_t      rx_resp
);

   import sd_pkg::*;

   localparam int TW = $clog2(RESP_TIMEOUT + 1);

   typedef enum logic [1:0] {IDLE, HUNT, SHIFT, DONE} rx_state_e;

   rx_state_e              state;
   logic [TW-1:0]          tmo_cnt;  // Rises seen without a start bit
   logic [7:0]             bit_cnt;  // Bits captured so far
   logic [7:0]             resp_len;
   logic [LONG_RESP_W-1:0] shreg;
   logic                   crc_ok_q;
   logic                   tmo_q;
   logic                   chk;
   logic                   start_seen;
   logic                   take_bit;
   logic                   crc_clr;
   logic                   crc_shift;
   sd_crc7_t               crc;

   // R2 is long, R2/R3 carry no usable CRC
   assign resp_len = (rx_kind == RESP_R2) ? 8'(LONG_RESP_W) : 8'(FRAME_W);
   assign chk      = (rx_kind == RESP_R1) || (rx_kind == RESP_R6) || (rx_kind == RESP_R7);

   assign start_seen = (state == HUNT) && sd_rise && !cmd_in;
   assign take_bit   = start_seen || ((state == SHIFT) && sd_rise && (bit_cnt < resp_len));
   assign crc_clr    = (state == IDLE) && rx_req;
   // Start bit counts as bit 0 of the covered span
   assign crc_shift  = chk && (start_seen ||
                       ((state == SHIFT) && sd_rise && (bit_cnt < 8'(CRC_SPAN))));

   sd_crc7 u_crc (
      .CLK    (CLK),
      .arst_n (arst_n),
      .clear  (crc_clr),
      .shift  (crc_shift),
      .din    (cmd_in),
      .crc    (crc)
   );

   // Shift in from the right so short responses end up right-aligned
   always_ff @(posedge CLK)
   begin
      if (crc_clr)
         shreg <= '0;
      else if (take_bit)
         shreg <= {shreg[LONG_RESP_W-2:0], cmd_in};
   end

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= IDLE;
         tmo_cnt  <= '0;
         bit_cnt  <= '0;
         crc_ok_q <= 1'b0;
         tmo_q    <= 1'b0;
         rx_ack   <= 1'b0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (rx_req)
               begin
                  tmo_cnt  <= '0;
                  tmo_q    <= 1'b0;
                  crc_ok_q <= 1'b0;
                  state    <= HUNT;
               end
            end
            HUNT:
            begin
               if (start_seen)
               begin
                  bit_cnt <= 8'd1;
                  state   <= SHIFT;
               end
               else if (sd_rise && (tmo_cnt == TW'(RESP_TIMEOUT - 1)))
               begin
                  tmo_q  <= 1'b1;  // Card never answered
                  rx_ack <= 1'b1;
                  state  <= DONE;
               end
               else if (sd_rise)
                  tmo_cnt <= tmo_cnt + 1'b1;
            end
            SHIFT:
            begin
               if (bit_cnt == resp_len)
               begin
                  // Received CRC field sits just above the end bit
                  crc_ok_q <= !chk || (shreg[7:1] == crc);
                  rx_ack   <= 1'b1;
                  state    <= DONE;
               end
               else if (sd_rise)
                  bit_cnt <= bit_cnt + 1'b1;
            end
            default:
            begin
               if (!rx_req)
               begin
                  rx_ack <= 1'b0;
                  state  <= IDLE;
               end
            end
         endcase
      end
   end

   assign rx_resp = '{payload: shreg, crc_ok: crc_ok_q, timeout: tmo_q};

endmodule

// ==== src/sd_init_seq.sv ====
`timescale 1ns/1ps

module sd_init_seq #(
   parameter int INIT_CLKS    = 80,
   parameter int ACMD41_TRIES = 20
) (
   input  logic                  CLK,
   input  logic                  arst_n,
   input  logic                  sd_rise,
   output logic                  tx_req,
   output sd_pkg::sd_cmd_t       tx_cmd,
   input  logic                  tx_ack,
   output logic                  rx_req,
   output sd_pkg::sd_resp_kind_e rx_kind,
   input  logic                  rx_ack,
   input  sd_pkg::sd_resp_t      rx_resp,
   output sd_pkg::sd_cid_t       cid,
   output sd_pkg::sd_rca_t       rca,
   output logic                  init_done,
   output logic                  led
);

   import sd_pkg::*;

   localparam int PW = $clog2(INIT_CLKS + 1);
   localparam int AW = $clog2(ACMD41_TRIES + 1);

   typedef enum logic [2:0] {
      WAIT_POWER, ISSUE, SEND, RECEIVE, DECIDE, READY, FAIL
   } seq_state_e;

   seq_state_e  state;
   sd_cmd_idx_t cur_idx;  // Command in flight, also the step pointer
   logic [PW-1:0] pwr_cnt;
   logic [AW-1:0] tries;  // ACMD41 answers with card still busy
   logic          resp_bad;

   // Argument and expected response follow from the index
   always_comb
   begin
      tx_cmd.idx = cur_idx;
      tx_cmd.arg = '0;
      rx_kind    = RESP_NONE;
      case (cur_idx)
         CMD8_IDX:
         begin
            tx_cmd.arg = CMD8_ARG;
            rx_kind    = RESP_R7;
         end
         CMD55_IDX: rx_kind = RESP_R1;
         CMD41_IDX:
         begin
            tx_cmd.arg = ACMD41_ARG;
            rx_kind    = RESP_R3;
         end
         CMD2_IDX: rx_kind = RESP_R2;
         CMD3_IDX: rx_kind = RESP_R6;
         default: rx_kind = RESP_NONE;  // CMD0 gets no answer
      endcase
   end

   assign resp_bad  = rx_resp.timeout || !rx_resp.crc_ok;
   assign init_done = (state == READY);
   assign led       = (state == FAIL);

   always_ff @(posedge CLK or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state   <= WAIT_POWER;
         cur_idx <= CMD0_IDX;
         pwr_cnt <= '0;
         tries   <= '0;
         tx_req  <= 1'b0;
         rx_req  <= 1'b0;
         cid     <= '0;
         rca     <= '0;
      end
      else
      begin
         case (state)
            WAIT_POWER:
            begin
               // Card needs its power-up clocks first
               if (sd_rise && (pwr_cnt == PW'(INIT_CLKS - 1)))
                  state <= ISSUE;
               else if (sd_rise)
                  pwr_cnt <= pwr_cnt + 1'b1;
            end
            ISSUE:
            begin
               if (!tx_ack)
               begin
                  tx_req <= 1'b1;
                  state  <= SEND;
               end
            end
            SEND:
            begin
               if (tx_ack)
               begin
                  tx_req <= 1'b0;
                  if (rx_kind == RESP_NONE)
                     state <= DECIDE;
                  else
                  begin
                     rx_req <= 1'b1;  // Hunt before the card's NCR gap ends
                     state  <= RECEIVE;
                  end
               end
            end
            RECEIVE:
            begin
               if (rx_ack)
                  state <= DECIDE;  // Response held while ack is up
            end
            DECIDE:
            begin
               rx_req <= 1'b0;
               state  <= ISSUE;
               if ((rx_kind != RESP_NONE) && resp_bad)
                  state <= FAIL;
               else
               begin
                  case (cur_idx)
                     CMD0_IDX: cur_idx <= CMD8_IDX;
                     CMD8_IDX:
                     begin
                        if (rx_resp.payload[15:8] != CMD8_ARG[7:0])
                           state <= FAIL;  // Pattern not echoed
                        else
                           cur_idx <= CMD55_IDX;
                     end
                     CMD55_IDX: cur_idx <= CMD41_IDX;
                     CMD41_IDX:
                     begin
                        if (rx_resp.payload[39])  // OCR power-up done
                           cur_idx <= CMD2_IDX;
                        else if (tries == AW'(ACMD41_TRIES - 1))
                           state <= FAIL;
                        else
                        begin
                           tries   <= tries + 1'b1;
                           cur_idx <= CMD55_IDX;
                        end
                     end
                     CMD2_IDX:
                     begin
                        cid     <= rx_resp.payload[127:0];
                        cur_idx <= CMD3_IDX;
                     end
                     default:
                     begin
                        rca   <= rx_resp.payload[39:24];  // R6 published RCA
                        state <= READY;
                     end
                  endcase
               end
            end
            default: state <= state;  // READY and FAIL hold until reset
         endcase
      end
   end

   // Engines only answer a request that is still up
   a_tx_ack_req : assert property (@(posedge CLK) disable iff (!arst_n)
      $rose(tx_ack) |-> tx_req);
   a_rx_ack_req : assert property (@(posedge CLK) disable iff (!arst_n)
      $rose(rx_ack) |-> rx_req);

endmodule

// ==== src/sd_init_top.sv ====
`timescale 1ns/1ps

module sd_init_top #(
   parameter int SD_CLK_HALF  = 2,
   parameter int INIT_CLKS    = 80,
   parameter int RESP_TIMEOUT = 64,
   parameter int ACMD41_TRIES = 20
) (
   input  logic            CLK,
   input  logic            arst_n,
   output logic            SD_CLK,
   inout  wire             CMD,
   output logic            led,
   output logic            init_done,
   output sd_pkg::sd_cid_t cid,
   output sd_pkg::sd_rca_t rca
);

   import sd_pkg::*;

   logic          sd_rise;
   logic          sd_fall;
   logic          tx_req;
   logic          tx_ack;
   sd_cmd_t       tx_cmd;
   logic          rx_req;
   logic          rx_ack;
   sd_resp_kind_e rx_kind;
   sd_resp_t      rx_resp;
   logic          cmd_out;
   logic          cmd_oe;

   // Host drives CMD only while a frame is out
   assign CMD = cmd_oe ? cmd_out : 1'bz;

   sd_clk_gen #(.SD_CLK_HALF(SD_CLK_HALF)) u_clk (
      .CLK(CLK), .arst_n(arst_n), .sd_clk(SD_CLK), .sd_rise(sd_rise), .sd_fall(sd_fall)
   );

   sd_cmd_tx u_tx (
      .CLK(CLK), .arst_n(arst_n), .sd_fall(sd_fall), .tx_req(tx_req), .tx_cmd(tx_cmd),
      .tx_ack(tx_ack), .cmd_out(cmd_out), .cmd_oe(cmd_oe)
   );

   sd_resp_rx #(.RESP_TIMEOUT(RESP_TIMEOUT)) u_rx (
      .CLK(CLK), .arst_n(arst_n), .sd_rise(sd_rise), .cmd_in(CMD), .rx_req(rx_req),
      .rx_kind(rx_kind), .rx_ack(rx_ack), .rx_resp(rx_resp)
   );

   sd_init_seq #(.INIT_CLKS(INIT_CLKS), .ACMD41_TRIES(ACMD41_TRIES)) u_seq (
      .CLK(CLK), .arst_n(arst_n), .sd_rise(sd_rise), .tx_req(tx_req), .tx_cmd(tx_cmd),
      .tx_ack(tx_ack), .rx_req(rx_req), .rx_kind(rx_kind), .rx_ack(rx_ack),
      .rx_resp(rx_resp), .cid(cid), .rca(rca), .init_done(init_done), .led(led)
   );

   // Receiver never listens while the host still owns the pin
   a_no_contention : assert property (@(posedge CLK) disable iff (!arst_n)
      rx_req |-> !cmd_oe);

endmodule

// ==== tb/sd_card_model.sv ====
`timescale 1ns/1ps

module sd_card_model (
   input  logic            sd_clk,
   input  logic            rst_n,
   inout  wire             cmd,
   input  int              busy_cnt,
   input  sd_pkg::sd_cid_t cid_val,
   input  sd_pkg::sd_rca_t rca_val,
   input  logic [1:0]      fault,
   output int              cmd0_cnt,
   output int              cmd55_cnt,
   output int              acmd41_cnt,
   output int              crc_err_cnt
);

   import sd_pkg::*;

   localparam logic [1:0] FAULT_SILENT  = 2'd1;  // No answer to CMD8
   localparam logic [1:0] FAULT_BAD_CRC = 2'd2;  // CMD8 answer CRC flipped
   localparam logic [1:0] FAULT_PATTERN = 2'd3;  // CMD8 echoes a wrong pattern

   logic drive_low   = 1'b0;  // Open drain, only ever pulls low
   logic app_cmd     = 1'b0;  // Previous command was CMD55
   int   busy_left   = 0;     // ACMD41 answers still reporting busy
   int   epoch       = 0;     // Bumped by every host reset
   int   frame_epoch = 0;     // Epoch the current exchange started in
   int   n_cmd0      = 0;
   int   n_cmd55     = 0;
   int   n_acmd41    = 0;
   int   n_crc_err   = 0;

   assign cmd         = drive_low ? 1'b0 : 1'bz;
   assign cmd0_cnt    = n_cmd0;
   assign cmd55_cnt   = n_cmd55;
   assign acmd41_cnt  = n_acmd41;
   assign crc_err_cnt = n_crc_err;

   // x^7 + x^3 + 1 over the 40 header bits, MSB first
   function automatic logic [6:0] crc7_of(input logic [39:0] bits);
      logic [6:0] c;
      logic       fb;
      c = 7'h00;
      for (int i = 39; i >= 0; i--)
      begin
         fb = bits[i] ^ c[6];
         c  = {c[5:0], 1'b0};
         if (fb)
            c = c ^ 7'b000_1001;  // x^3 and x^0 taps
      end
      return c;
   endfunction

   // NCR gap of two SD clocks, then one bit per falling edge
   task automatic send_frame(input logic [135:0] bits, input int n);
      repeat (2) @(negedge sd_clk);
      for (int k = n - 1; (k >= 0) && (epoch == frame_epoch); k--)
      begin
         drive_low = !bits[k];
         @(negedge sd_clk);
      end
      drive_low = 1'b0;  // Line back to the pull-up
   endtask

   task automatic send_short(input logic [5:0] idx, input logic [31:0] body, input logic bad);
      logic [39:0] head;
      logic [6:0]  c;
      head = {2'b00, idx, body};
      c    = crc7_of(head);
      if (bad)
         c = c ^ 7'h01;  // Single flipped CRC bit
      send_frame({88'h0, head, c, 1'b1}, 48);
   endtask

   task automatic answer_command(input logic [47:0] f);
      logic [5:0]  idx;
      logic [31:0] arg;
      logic [6:0]  got;
      logic [7:0]  echo;
      idx  = f[45:40];
      arg  = f[39:8];
      got  = f[7:1];
      echo = (fault == FAULT_PATTERN) ? 8'h55 : arg[7:0];
      // Known CRCs of CMD0 and CMD8 also catch a broken local CRC
      if ((got !== crc7_of(f[47:8])) || ((idx == 6'd0) && (got !== 7'h4A)) ||
          ((idx == 6'd8) && (arg == 32'h0000_01AA) && (got !== 7'h43)))
      begin
         n_crc_err++;
         $display("Card model got CMD%0d with CRC 0x%0h, expected 0x%0h",
                  idx, got, crc7_of(f[47:8]));
      end
      case (idx)
         6'd0:
         begin
            n_cmd0++;
            busy_left = busy_cnt;  // Power-up busy restarts with idle
         end
         6'd8:
         begin
            if (fault != FAULT_SILENT)
               send_short(6'd8, {20'h0, arg[11:8], echo}, fault == FAULT_BAD_CRC);
         end
         6'd55:
         begin
            n_cmd55++;
            send_short(6'd55, 32'h0000_0120, 1'b0);  // Status with APP_CMD set
         end
         6'd41:
         begin
            if (app_cmd)
            begin
               n_acmd41++;
               // R3 carries OCR, reserved bits instead of CRC
               send_frame({88'h0, 2'b00, 6'h3F, (busy_left == 0), 1'b1, 6'h00, 24'hFF8000,
                           7'h7F, 1'b1}, 48);
               if (busy_left > 0)
                  busy_left--;
            end
         end
         6'd2: send_frame({2'b00, 6'h3F, cid_val}, 136);  // R2 with the CID
         6'd3: send_short(6'd3, {rca_val, 16'h0500}, 1'b0);
         default: ;  // Anything else goes unanswered
      endcase
      app_cmd = (idx == 6'd55);
   endtask

   // Host reset drops any exchange in flight
   always @(negedge rst_n)
   begin
      epoch++;
      drive_low = 1'b0;
      app_cmd   = 1'b0;
      n_cmd0    = 0;
      n_cmd55   = 0;
      n_acmd41  = 0;
      n_crc_err = 0;
   end

   always
   begin : serve
      logic [47:0] f;
      wait (rst_n === 1'b1);
      @(posedge sd_clk);
      if (cmd === 1'b0)  // Start bit of a command
      begin
         frame_epoch = epoch;
         f[47]       = 1'b0;
         for (int i = 46; (i >= 0) && (epoch == frame_epoch); i--)
         begin
            @(posedge sd_clk);
            f[i] = cmd;
         end
         if (epoch == frame_epoch)
            answer_command(f);
      end
   end

endmodule

// ==== tb/tb_sd_init.sv ====
`timescale 1ns/1ps

module tb_sd_init;

   import sd_pkg::*;

   localparam int SD_CLK_HALF  = 2;
   localparam int INIT_CLKS    = 80;
   localparam int RESP_TIMEOUT = 64;
   localparam int ACMD41_TRIES = 20;
   localparam int CLK_NS       = 20;

   localparam logic [1:0] FAULT_NONE    = 2'd0;
   localparam logic [1:0] FAULT_SILENT  = 2'd1;
   localparam logic [1:0] FAULT_BAD_CRC = 2'd2;
   localparam logic [1:0] FAULT_PATTERN = 2'd3;

   // Worst case per command in SD clocks: frame, NCR gap, answer, handshakes
   localparam int     CMD_SLOT    = 2 * FRAME_W + 16;
   localparam int     RUN_SD      = INIT_CLKS + (4 + 2 * ACMD41_TRIES) * CMD_SLOT
                                    + LONG_RESP_W + RESP_TIMEOUT;
   localparam int     RUN_CLKS    = RUN_SD * 2 * SD_CLK_HALF;
   localparam int     NUM_RUNS    = 8;  // Tests 5 and 6 run twice
   localparam longint WATCHDOG_NS = 2 * NUM_RUNS * longint'(RUN_CLKS + 16) * CLK_NS;

   logic    CLK;
   logic    arst_n;
   logic    SD_CLK;
   wire     CMD;
   logic    led;
   logic    init_done;
   sd_cid_t cid;
   sd_rca_t rca;

   int         busy_cnt;  // Card model setup
   sd_cid_t    card_cid;
   sd_rca_t    card_rca;
   logic [1:0] fault;
   int         cmd0_cnt;
   int         cmd55_cnt;
   int         acmd41_cnt;
   int         crc_err_cnt;
   int         errors;
   integer     seed;

   pullup (CMD);  // Idle level of the open-drain line

   sd_init_top #(
      .SD_CLK_HALF  (SD_CLK_HALF),
      .INIT_CLKS    (INIT_CLKS),
      .RESP_TIMEOUT (RESP_TIMEOUT),
      .ACMD41_TRIES (ACMD41_TRIES)
   ) dut (
      .CLK(CLK), .arst_n(arst_n), .SD_CLK(SD_CLK), .CMD(CMD), .led(led),
      .init_done(init_done), .cid(cid), .rca(rca)
   );

   sd_card_model card (
      .sd_clk(SD_CLK), .rst_n(arst_n), .cmd(CMD), .busy_cnt(busy_cnt), .cid_val(card_cid),
      .rca_val(card_rca), .fault(fault), .cmd0_cnt(cmd0_cnt), .cmd55_cnt(cmd55_cnt),
      .acmd41_cnt(acmd41_cnt), .crc_err_cnt(crc_err_cnt)
   );

   initial
   begin
      CLK = 1'b0;
      forever #(CLK_NS / 2) CLK = ~CLK;
   end

   initial
   begin : watchdog
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
      $display("Finished with errors");
      $finish;
   end

   task automatic report_mismatch(input string name, input logic [127:0] got,
                                  input logic [127:0] exp);
      errors++;
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
   endtask

   // Reset for 4 clocks with a fresh card identity
   task automatic apply_reset(input int busy, input logic [1:0] flt);
      @(posedge CLK);
      #2;
      arst_n   = 1'b0;
      busy_cnt = busy;
      fault    = flt;
      card_cid = {$random(seed), $random(seed), $random(seed), $random(seed)} | 128'h1;
      card_rca = 16'($random(seed));
      repeat (4) @(posedge CLK);
      #2;
      arst_n = 1'b1;
   endtask

   task automatic wait_result();
      int n;
      n = 0;
      while (!(init_done || led) && (n < RUN_CLKS))
      begin
         @(negedge CLK);  // Mid-cycle, outputs settled
         n++;
      end
      if (!(init_done || led))
      begin
         errors++;
         $display("Neither init_done nor led rose within %0d clock cycles", RUN_CLKS);
      end
   endtask

   task automatic expect_success();
      if (init_done !== 1'b1) report_mismatch("init_done", init_done, 1);
      if (led !== 1'b0) report_mismatch("led", led, 0);
      if (cid !== card_cid) report_mismatch("cid", cid, card_cid);
      if (rca !== card_rca) report_mismatch("rca", rca, card_rca);
   endtask

   task automatic expect_failure();
      if (led !== 1'b1) report_mismatch("led", led, 1);
      if (init_done !== 1'b0) report_mismatch("init_done", init_done, 0);
   endtask

   task automatic run_normal();
      apply_reset(0, FAULT_NONE);
      wait_result();
      expect_success();
      if (crc_err_cnt != 0) report_mismatch("crc_err_cnt", crc_err_cnt, 0);
      if (cmd0_cnt != 1) report_mismatch("cmd0_cnt", cmd0_cnt, 1);
   endtask

   task automatic run_acmd41_retry();
      int busy;
      busy = $unsigned($random(seed)) % 6;
      apply_reset(busy, FAULT_NONE);
      wait_result();
      expect_success();
      if (cmd55_cnt != busy + 1) report_mismatch("cmd55_cnt", cmd55_cnt, busy + 1);
      if (acmd41_cnt != busy + 1) report_mismatch("acmd41_cnt", acmd41_cnt, busy + 1);
   endtask

   task automatic run_retry_limit();
      apply_reset(ACMD41_TRIES + 3, FAULT_NONE);  // Card never leaves busy
      wait_result();
      expect_failure();
      if (acmd41_cnt != ACMD41_TRIES) report_mismatch("acmd41_cnt", acmd41_cnt, ACMD41_TRIES);
   endtask

   task automatic run_resp_timeout();
      apply_reset(0, FAULT_SILENT);
      wait_result();
      expect_failure();
      if (cmd55_cnt != 0) report_mismatch("cmd55_cnt", cmd55_cnt, 0);
   endtask

   task automatic run_resp_check();
      apply_reset(0, FAULT_BAD_CRC);
      wait_result();
      expect_failure();
      if (cmd55_cnt != 0) report_mismatch("cmd55_cnt", cmd55_cnt, 0);
      apply_reset(0, FAULT_PATTERN);  // CRC fine, echo wrong
      wait_result();
      expect_failure();
      if (cmd55_cnt != 0) report_mismatch("cmd55_cnt", cmd55_cnt, 0);
   endtask

   task automatic run_mid_reset();
      int n;
      apply_reset(8, FAULT_NONE);
      n = 0;
      while ((acmd41_cnt < 3) && (n < RUN_CLKS))
      begin
         @(negedge CLK);
         n++;
      end
      if (acmd41_cnt < 3)
      begin
         errors++;
         $display("The ACMD41 loop was not reached before the mid-run reset");
      end
      @(posedge CLK);
      #2;
      arst_n   = 1'b0;
      busy_cnt = 1;
      @(negedge CLK);
      if (init_done !== 1'b0) report_mismatch("init_done", init_done, 0);
      if (led !== 1'b0) report_mismatch("led", led, 0);
      if (rca !== 16'h0) report_mismatch("rca", rca, 0);
      if (SD_CLK !== 1'b0) report_mismatch("SD_CLK", SD_CLK, 0);  // Was high at reset
      if (CMD !== 1'b1) report_mismatch("CMD", CMD, 1);  // Both sides released
      repeat (3) @(posedge CLK);
      #2;
      arst_n = 1'b1;
      wait_result();
      expect_success();
      if (cmd0_cnt != 1) report_mismatch("cmd0_cnt", cmd0_cnt, 1);
   endtask

   initial
   begin
      arst_n   = 1'b0;
      busy_cnt = 0;
      fault    = FAULT_NONE;
      card_cid = '0;
      card_rca = '0;
      errors   = 0;
      seed     = 78332;
      run_normal();
      run_acmd41_retry();
      run_retry_limit();
      run_resp_timeout();
      run_resp_check();
      run_mid_reset();
      $display("Tests run: 6, errors: %0d", errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

// ==== sim.f ====
src/sd_pkg.sv
src/sd_clk_gen.sv
src/sd_crc7.sv
src/sd_cmd_tx.sv
src/sd_resp_rx.sv
src/sd_init_seq.sv
src/sd_init_top.sv
tb/sd_card_model.sv
tb/tb_sd_init.sv

// ==== Bender.yml ====
package:
  name: sd_init

sources:
  - files:
      - src/sd_pkg.sv
      - src/sd_clk_gen.sv
      - src/sd_crc7.sv
      - src/sd_cmd_tx.sv
      - src/sd_resp_rx.sv
      - src/sd_init_seq.sv
      - src/sd_init_top.sv
  - target: test
    files:
      - tb/sd_card_model.sv
      - tb/tb_sd_init.sv
